// File: Makefile
# Verilator build and run of the load/store unit testbench
VERILATOR ?= verilator
TOP       ?= tb_lsu
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
MEM_DELAY ?= 0
PASS_MSG  ?= No errors
VFLAGS    ?= --timing --assert
DEFINES   ?= +define+MEM_DELAY_EN=$(MEM_DELAY)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) $(DEFINES) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

lint:
	$(VERILATOR) --lint-only $(VFLAGS) $(DEFINES) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hdl/data_mem.sv
// byte-strobed data memory as an AXI-lite slave with LFSR wait states and range error
`timescale 1ns/10ps
`include "lsu_config.svh"

module data_mem (
	input  logic               clk,
	input  logic               rstn,
	input  lsu_pkg::axi_aw_t   ar_i,
	input  logic               ar_valid_i,
	output logic               ar_ready_o,
	output lsu_pkg::axi_r_t    r_o,
	output logic               r_valid_o,
	input  logic               r_ready_i,
	input  lsu_pkg::axi_aw_t   aw_i,
	input  logic               aw_valid_i,
	output logic               aw_ready_o,
	input  lsu_pkg::axi_w_t    w_i,
	input  logic               w_valid_i,
	output logic               w_ready_o,
	output lsu_pkg::axi_resp_e b_resp_o,
	output logic               b_valid_o,
	input  logic               b_ready_i
);
	import lsu_pkg::*;

	localparam int IDX_W = $clog2(`MEM_WORDS);
	localparam logic [`LSU_ADDR_W-1:0] MEM_BYTES = `LSU_ADDR_W'(`MEM_WORDS * 4);
	localparam bit DELAY_EN = (`MEM_DELAY_EN != 0);
	localparam logic [7:0] LFSR_SEED = `MEM_LFSR_SEED;

	logic [`LSU_DATA_W-1:0] mem [`MEM_WORDS];
	logic [7:0]             lfsr_q;
	logic [2:0]             dly_q;
	logic [2:0]             dly_new;
	logic                   busy_q;
	logic                   is_wr_q;
	logic [`LSU_DATA_W-1:0] rdata_q;
	axi_resp_e              resp_q;
	logic                   accept;
	logic                   rd_hs;
	logic                   wr_hs;
	logic                   resp_hs;
	logic                   rd_in_range;
	logic                   wr_in_range;
	logic [IDX_W-1:0]       rd_idx;
	logic [IDX_W-1:0]       wr_idx;

	assign rd_idx      = ar_i.addr[IDX_W+1:2];
	assign wr_idx      = aw_i.addr[IDX_W+1:2];
	assign rd_in_range = (ar_i.addr < MEM_BYTES);
	assign wr_in_range = (aw_i.addr < MEM_BYTES);

	// new address only when idle and the wait count has run out
	assign accept     = !busy_q && (dly_q == 3'd0);
	assign ar_ready_o = accept;
	// a read takes priority, the LSU never raises both
	assign aw_ready_o = accept && !ar_valid_i;
	assign w_ready_o  = accept && !ar_valid_i;

	assign rd_hs   = ar_valid_i && ar_ready_o;
	assign wr_hs   = aw_valid_i && aw_ready_o && w_valid_i && w_ready_o;
	assign resp_hs = (r_valid_o && r_ready_i) || (b_valid_o && b_ready_i);

	// response valid stays up until taken since dly_q stays at zero
	assign r_valid_o = busy_q && !is_wr_q && (dly_q == 3'd0);
	assign b_valid_o = busy_q && is_wr_q && (dly_q == 3'd0);
	assign r_o.data  = rdata_q;
	assign r_o.resp  = resp_q;
	assign b_resp_o  = resp_q;

	// x^8 + x^6 + x^5 + x^4 + 1
	always_ff @(posedge clk) begin
		if (!rstn) begin
			lfsr_q <= LFSR_SEED;
		end else begin
			lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
		end
	end

	assign dly_new = DELAY_EN ? lfsr_q[2:0] : 3'd0;

	// reload at every handshake, count down otherwise
	always_ff @(posedge clk) begin
		if (!rstn) begin
			busy_q  <= 1'b0;
			is_wr_q <= 1'b0;
			dly_q   <= 3'd0;
		end else begin
			if (rd_hs || wr_hs || resp_hs) begin
				dly_q <= dly_new;
			end else if (dly_q != 3'd0) begin
				dly_q <= dly_q - 3'd1;
			end
			if (rd_hs || wr_hs) begin
				busy_q  <= 1'b1;
				is_wr_q <= wr_hs;
			end else if (resp_hs) begin
				busy_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rd_hs) begin
			rdata_q <= rd_in_range ? mem[rd_idx] : '0;
			resp_q  <= rd_in_range ? RESP_OKAY : RESP_SLVERR;
		end else if (wr_hs) begin
			resp_q <= wr_in_range ? RESP_OKAY : RESP_SLVERR;
		end
	end

	// contents start at zero, out-of-range writes are dropped
	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int i = 0; i < `MEM_WORDS; i++) begin
				mem[i] <= '0;
			end
		end else if (wr_hs && wr_in_range) begin
			for (int b = 0; b < `LSU_DATA_W/8; b++) begin
				if (w_i.strb[b]) begin
					mem[wr_idx][8*b +: 8] <= w_i.data[8*b +: 8];
				end
			end
		end
	end

endmodule

// File: hdl/lsu.sv
// load/store unit with request FSM, AXI-lite master channels, store lanes and load extension
`timescale 1ns/10ps
`include "lsu_config.svh"

module lsu (
	input  logic               clk,
	input  logic               rstn,
	input  logic               req_valid_i,
	input  lsu_pkg::lsu_req_t  req_i,
	output logic               ready_o,
	output lsu_pkg::axi_aw_t   ar_o,
	output logic               ar_valid_o,
	input  logic               ar_ready_i,
	input  lsu_pkg::axi_r_t    r_i,
	input  logic               r_valid_i,
	output logic               r_ready_o,
	output lsu_pkg::axi_aw_t   aw_o,
	output logic               aw_valid_o,
	input  logic               aw_ready_i,
	output lsu_pkg::axi_w_t    w_o,
	output logic               w_valid_o,
	input  logic               w_ready_i,
	input  lsu_pkg::axi_resp_e b_resp_i,
	input  logic               b_valid_i,
	output logic               b_ready_o,
	output lsu_pkg::wb_t       wb_o,
	output logic               wb_valid_o
);
	import lsu_pkg::*;

	lsu_state_e state_q;
	lsu_state_e state_d;
	lsu_req_t   req_q;
	wb_t        wb_q;
	wb_t        wb_d;
	logic       is_load;
	logic       is_store;
	logic       addr_hs;
	logic       resp_hs;
	logic [7:0]  ld_byte;
	logic [15:0] ld_half;
	logic [`LSU_DATA_W-1:0] ld_data;

	assign is_load  = req_q.op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
	assign is_store = req_q.op inside {OP_SB, OP_SH, OP_SW};

	// only one request in flight, accepted in idle
	assign ready_o = (state_q == ST_IDLE);

	always_ff @(posedge clk) begin
		if (ready_o && req_valid_i) begin
			req_q <= req_i;
		end
	end

	// channel controls follow the state, so payloads hold until the handshake
	assign ar_valid_o = (state_q == ST_ADDR) && is_load;
	assign aw_valid_o = (state_q == ST_ADDR) && is_store;
	assign w_valid_o  = (state_q == ST_ADDR) && is_store;
	assign r_ready_o  = (state_q == ST_RESP) && is_load;
	assign b_ready_o  = (state_q == ST_RESP) && is_store;

	// word aligned address, lane selection uses the low bits of req_q
	assign ar_o.addr = {req_q.addr[`LSU_ADDR_W-1:2], 2'b00};
	assign aw_o.addr = {req_q.addr[`LSU_ADDR_W-1:2], 2'b00};

	// aw and w are accepted together by the memory
	assign addr_hs = (ar_valid_o && ar_ready_i) ||
		(aw_valid_o && aw_ready_i && w_valid_o && w_ready_i);
	assign resp_hs = (r_valid_i && r_ready_o) || (b_valid_i && b_ready_o);

	// store data replicated onto the byte lanes
	always_comb begin
		case (req_q.op)
			OP_SB: begin
				w_o.data = {4{req_q.wdata[7:0]}};
				w_o.strb = 4'b0001 << req_q.addr[1:0];
			end
			OP_SH: begin
				w_o.data = {2{req_q.wdata[15:0]}};
				w_o.strb = req_q.addr[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				w_o.data = req_q.wdata;
				w_o.strb = 4'b1111;
			end
		endcase
	end

	// pick the addressed byte or half out of the read word
	assign ld_byte = r_i.data[8*req_q.addr[1:0] +: 8];
	assign ld_half = req_q.addr[1] ? r_i.data[31:16] : r_i.data[15:0];

	always_comb begin
		case (req_q.op)
			OP_LB:   ld_data = {{24{ld_byte[7]}}, ld_byte};
			OP_LBU:  ld_data = {24'd0, ld_byte};
			OP_LH:   ld_data = {{16{ld_half[15]}}, ld_half};
			OP_LHU:  ld_data = {16'd0, ld_half};
			default: ld_data = r_i.data;
		endcase
	end

	// writeback record, non-memory ops write back the ALU result carried in addr
	always_comb begin
		wb_d.rd    = req_q.rd;
		wb_d.data  = '0;
		wb_d.wen   = 1'b0;
		wb_d.fault = 1'b0;
		if (is_load) begin
			wb_d.data  = ld_data;
			wb_d.fault = (r_i.resp == RESP_SLVERR);
			wb_d.wen   = (r_i.resp != RESP_SLVERR);
		end else if (is_store) begin
			wb_d.fault = (b_resp_i == RESP_SLVERR);
		end else begin
			wb_d.data = req_q.addr;
			wb_d.wen  = 1'b1;
		end
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: begin
				if (req_valid_i) begin
					state_d = ST_ADDR;
				end
			end
			ST_ADDR: begin
				if (!is_load && !is_store) begin
					state_d = ST_WB;
				end else if (addr_hs) begin
					state_d = ST_RESP;
				end
			end
			ST_RESP: begin
				if (resp_hs) begin
					state_d = ST_WB;
				end
			end
			ST_WB: begin
				state_d = ST_IDLE;
			end
			default: begin
				state_d = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state_q <= ST_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// record captured on entry to ST_WB while response data is still valid
	always_ff @(posedge clk) begin
		if (state_q != ST_WB && state_d == ST_WB) begin
			wb_q <= wb_d;
		end
	end

	assign wb_o       = wb_q;
	assign wb_valid_o = (state_q == ST_WB);

endmodule

// File: hdl/lsu_config.svh
// width, memory depth, delay enable and LFSR seed macros for the load/store unit
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// datapath widths of the RV32 load/store path
`define LSU_DATA_W 32
`define LSU_ADDR_W 32

// data memory depth in 32-bit words
// byte addresses at or above MEM_WORDS*4 get an error response
`define MEM_WORDS 256

// random ready/valid delays in the memory
// 0 gives a zero-wait memory, 1 gives 0 to 7 wait cycles per handshake
// the build overrides this value on the command line for the delay run
`define MEM_DELAY_EN 0

// start value of the delay LFSR, must not be zero
`define MEM_LFSR_SEED 8'h5b

`endif

// File: hdl/lsu_pkg.sv
// opcode, FSM state and response enums plus request, AXI-lite channel and writeback structs
`include "lsu_config.svh"

package lsu_pkg;

	// load/store opcodes, OP_NONE passes the ALU result through
	typedef enum logic [3:0] {
		OP_NONE = 4'd0,
		OP_LB   = 4'd1,
		OP_LH   = 4'd2,
		OP_LW   = 4'd3,
		OP_LBU  = 4'd4,
		OP_LHU  = 4'd5,
		OP_SB   = 4'd6,
		OP_SH   = 4'd7,
		OP_SW   = 4'd8
	} lsu_op_e;

	typedef enum logic [1:0] {
		ST_IDLE = 2'd0,
		ST_ADDR = 2'd1,
		ST_RESP = 2'd2,
		ST_WB   = 2'd3
	} lsu_state_e;

	// AXI encodings, only OKAY and SLVERR are produced
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} axi_resp_e;

	typedef struct packed {
		lsu_op_e                 op;
		logic [`LSU_ADDR_W-1:0]  addr;
		logic [`LSU_DATA_W-1:0]  wdata;
		logic [4:0]              rd;
	} lsu_req_t;

	// shared by the read and write address channels
	typedef struct packed {
		logic [`LSU_ADDR_W-1:0] addr;
	} axi_aw_t;

	typedef struct packed {
		logic [`LSU_DATA_W-1:0]   data;
		logic [`LSU_DATA_W/8-1:0] strb;
	} axi_w_t;

	typedef struct packed {
		logic [`LSU_DATA_W-1:0] data;
		axi_resp_e              resp;
	} axi_r_t;

	typedef struct packed {
		logic [4:0]             rd;
		logic [`LSU_DATA_W-1:0] data;
		logic                   wen;
		logic                   fault;
	} wb_t;

endpackage

// File: hdl/lsu_top.sv
// top level wiring the LSU to the data memory and the writeback register file
`timescale 1ns/10ps
`include "lsu_config.svh"

module lsu_top (
	input  logic                   clk,
	input  logic                   rstn,
	input  logic                   req_valid_i,
	input  lsu_pkg::lsu_req_t      req_i,
	output logic                   ready_o,
	output logic                   done_o,
	input  logic [4:0]             rf_raddr_i,
	output logic [`LSU_DATA_W-1:0] rf_rdata_o,
	output logic [7:0]             fault_count_o
);
	import lsu_pkg::*;

	axi_aw_t   ar;
	logic      ar_valid;
	logic      ar_ready;
	axi_r_t    r;
	logic      r_valid;
	logic      r_ready;
	axi_aw_t   aw;
	logic      aw_valid;
	logic      aw_ready;
	axi_w_t    w;
	logic      w_valid;
	logic      w_ready;
	axi_resp_e b_resp;
	logic      b_valid;
	logic      b_ready;
	wb_t       wb;

	// done_o is the writeback pulse itself
	lsu u_lsu (
		.clk         (clk),
		.rstn        (rstn),
		.req_valid_i (req_valid_i),
		.req_i       (req_i),
		.ready_o     (ready_o),
		.ar_o        (ar),
		.ar_valid_o  (ar_valid),
		.ar_ready_i  (ar_ready),
		.r_i         (r),
		.r_valid_i   (r_valid),
		.r_ready_o   (r_ready),
		.aw_o        (aw),
		.aw_valid_o  (aw_valid),
		.aw_ready_i  (aw_ready),
		.w_o         (w),
		.w_valid_o   (w_valid),
		.w_ready_i   (w_ready),
		.b_resp_i    (b_resp),
		.b_valid_i   (b_valid),
		.b_ready_o   (b_ready),
		.wb_o        (wb),
		.wb_valid_o  (done_o)
	);

	data_mem u_data_mem (
		.clk        (clk),
		.rstn       (rstn),
		.ar_i       (ar),
		.ar_valid_i (ar_valid),
		.ar_ready_o (ar_ready),
		.r_o        (r),
		.r_valid_o  (r_valid),
		.r_ready_i  (r_ready),
		.aw_i       (aw),
		.aw_valid_i (aw_valid),
		.aw_ready_o (aw_ready),
		.w_i        (w),
		.w_valid_i  (w_valid),
		.w_ready_o  (w_ready),
		.b_resp_o   (b_resp),
		.b_valid_o  (b_valid),
		.b_ready_i  (b_ready)
	);

	wb_regfile u_wb_regfile (
		.clk           (clk),
		.rstn          (rstn),
		.wb_i          (wb),
		.wb_valid_i    (done_o),
		.rf_raddr_i    (rf_raddr_i),
		.rf_rdata_o    (rf_rdata_o),
		.fault_count_o (fault_count_o)
	);

endmodule

// File: hdl/wb_regfile.sv
// register file taking LSU writebacks, with x0 tied to zero, a read port and a fault counter
`timescale 1ns/10ps
`include "lsu_config.svh"

module wb_regfile (
	input  logic                   clk,
	input  logic                   rstn,
	input  lsu_pkg::wb_t           wb_i,
	input  logic                   wb_valid_i,
	input  logic [4:0]             rf_raddr_i,
	output logic [`LSU_DATA_W-1:0] rf_rdata_o,
	output logic [7:0]             fault_count_o
);
	import lsu_pkg::*;

	// x1 to x31, x0 has no storage
	logic [`LSU_DATA_W-1:0] regs [1:31];
	logic                   wr_en;

	assign wr_en = wb_valid_i && wb_i.wen && (wb_i.rd != 5'd0);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wb_i.rd] <= wb_i.data;
		end
	end

	assign rf_rdata_o = (rf_raddr_i == 5'd0) ? '0 : regs[rf_raddr_i];

	// saturates at 255
	always_ff @(posedge clk) begin
		if (!rstn) begin
			fault_count_o <= 8'd0;
		end else if (wb_valid_i && wb_i.fault && fault_count_o != 8'hff) begin
			fault_count_o <= fault_count_o + 8'd1;
		end
	end

endmodule

// File: tb.f
+incdir+hdl
hdl/lsu_pkg.sv
hdl/lsu.sv
hdl/data_mem.sv
hdl/wb_regfile.sv
hdl/lsu_top.sv
tb/lsu_checker.sv
tb/tb_lsu.sv

// File: tb/lsu_checker.sv
// concurrent assertions on the lsu handshakes, ready in idle and the writeback pulse, with bind
`timescale 1ns/10ps

module lsu_checker (
	input logic                   clk,
	input logic                   rstn,
	input lsu_pkg::lsu_state_e    state_i,
	input logic                   req_valid_i,
	input logic                   ready_i,
	input logic                   ar_valid_i,
	input logic                   ar_ready_i,
	input lsu_pkg::axi_aw_t       ar_i,
	input logic                   aw_valid_i,
	input logic                   aw_ready_i,
	input lsu_pkg::axi_aw_t       aw_i,
	input logic                   w_valid_i,
	input logic                   w_ready_i,
	input lsu_pkg::axi_w_t        w_i,
	input logic                   r_valid_i,
	input logic                   r_ready_i,
	input lsu_pkg::axi_r_t        r_i,
	input logic                   b_valid_i,
	input logic                   b_ready_i,
	input lsu_pkg::axi_resp_e     b_resp_i,
	input logic                   wb_valid_i
);
	import lsu_pkg::*;

	// valid held with a stable payload until the transfer
	a_ar_hold: assert property (@(posedge clk) disable iff (!rstn)
		ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_i))
		else $error("ar valid dropped or payload changed before ready");
	a_aw_hold: assert property (@(posedge clk) disable iff (!rstn)
		aw_valid_i && !aw_ready_i |=> aw_valid_i && $stable(aw_i))
		else $error("aw valid dropped or payload changed before ready");
	a_w_hold: assert property (@(posedge clk) disable iff (!rstn)
		w_valid_i && !w_ready_i |=> w_valid_i && $stable(w_i))
		else $error("w valid dropped or payload changed before ready");
	a_r_hold: assert property (@(posedge clk) disable iff (!rstn)
		r_valid_i && !r_ready_i |=> r_valid_i && $stable(r_i))
		else $error("r valid dropped or payload changed before ready");
	a_b_hold: assert property (@(posedge clk) disable iff (!rstn)
		b_valid_i && !b_ready_i |=> b_valid_i && $stable(b_resp_i))
		else $error("b valid dropped or response changed before ready");

	// an accepted strobe leaves idle on the next edge
	a_ready_accept: assert property (@(posedge clk) disable iff (!rstn)
		ready_i && req_valid_i |=> (state_i == ST_ADDR) && !ready_i)
		else $error("accepted request did not leave the idle state");

	// ready stays low while a channel or the writeback is active
	a_ready_busy: assert property (@(posedge clk) disable iff (!rstn)
		(ar_valid_i || aw_valid_i || w_valid_i || r_ready_i || b_ready_i ||
		wb_valid_i) |-> !ready_i)
		else $error("ready_o high outside the idle state");

	a_wb_pulse: assert property (@(posedge clk) disable iff (!rstn)
		wb_valid_i |=> !wb_valid_i)
		else $error("wb_valid held longer than one cycle");

endmodule

bind lsu lsu_checker u_lsu_checker (
	.clk         (clk),
	.rstn        (rstn),
	.state_i     (state_q),
	.req_valid_i (req_valid_i),
	.ready_i     (ready_o),
	.ar_valid_i  (ar_valid_o),
	.ar_ready_i  (ar_ready_i),
	.ar_i        (ar_o),
	.aw_valid_i  (aw_valid_o),
	.aw_ready_i  (aw_ready_i),
	.aw_i        (aw_o),
	.w_valid_i   (w_valid_o),
	.w_ready_i   (w_ready_i),
	.w_i         (w_o),
	.r_valid_i   (r_valid_i),
	.r_ready_i   (r_ready_o),
	.r_i         (r_i),
	.b_valid_i   (b_valid_i),
	.b_ready_i   (b_ready_o),
	.b_resp_i    (b_resp_i),
	.wb_valid_i  (wb_valid_o)
);

// File: tb/tb_lsu.sv
// testbench for lsu_top with clock, reset, random requests, reference model, checks and timeout
`timescale 1ns/10ps
`include "lsu_config.svh"

module tb_lsu;
	import lsu_pkg::*;

	localparam int N_NONE    = 8;
	localparam int N_STORE   = 40;
	localparam int N_LWCHK   = 16;
	localparam int N_WORDS   = 8;
	// one SW to fill the word, then four sub-word loads at each of four offsets
	localparam int N_SUB     = N_WORDS * 17;
	localparam int N_FAULT   = 18;
	localparam int N_REQ     = N_NONE + N_STORE + N_LWCHK + N_SUB + N_FAULT;
	localparam int MAX_CYC   = N_REQ * (2 * 8 + 4) + 200;
	localparam int MEM_BYTES = `MEM_WORDS * 4;

	logic        clk;
	logic        rstn;
	logic        req_valid_i;
	lsu_req_t    req_i;
	logic        ready_o;
	logic        done_o;
	logic [4:0]  rf_raddr_i;
	logic [31:0] rf_rdata_o;
	logic [7:0]  fault_count_o;

	// byte-wide memory and register file of the model
	logic [7:0]  mem_model [0:MEM_BYTES-1];
	logic [31:0] reg_model [0:31];
	int          fault_model;
	int          checks = 0;
	int          errors = 0;
	int          cycles = 0;

	lsu_top dut_i (
		.clk           (clk),
		.rstn          (rstn),
		.req_valid_i   (req_valid_i),
		.req_i         (req_i),
		.ready_o       (ready_o),
		.done_o        (done_o),
		.rf_raddr_i    (rf_raddr_i),
		.rf_rdata_o    (rf_rdata_o),
		.fault_count_o (fault_count_o)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYC) begin
			$display("timeout after %0d cycles, a request never completed", cycles);
			$display("Errors found");
			$finish;
		end
	end

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("ERR %0t %s got %08h exp %08h", $time, name, got, exp);
		end
	endtask

	function automatic lsu_op_e pick_store_op(input int unsigned sel);
		case (sel % 3)
			0:       return OP_SB;
			1:       return OP_SH;
			default: return OP_SW;
		endcase
	endfunction

	function automatic lsu_op_e pick_load_op(input int unsigned sel);
		case (sel % 5)
			0:       return OP_LB;
			1:       return OP_LH;
			2:       return OP_LW;
			3:       return OP_LBU;
			default: return OP_LHU;
		endcase
	endfunction

	// expected effect of one request on memory, registers and fault count
	task automatic apply_model(input lsu_op_e op, input logic [31:0] addr,
			input logic [31:0] wdata, input logic [4:0] rd);
		logic [9:0]  widx;
		logic [9:0]  hidx;
		logic [7:0]  bsel;
		logic [15:0] hsel;
		logic [31:0] word;
		logic [31:0] res;
		widx = {addr[9:2], 2'b00};
		hidx = {addr[9:1], 1'b0};
		bsel = mem_model[addr[9:0]];
		hsel = {mem_model[hidx + 10'd1], mem_model[hidx]};
		word = {mem_model[widx + 10'd3], mem_model[widx + 10'd2],
			mem_model[widx + 10'd1], mem_model[widx]};
		res = addr;
		if (op != OP_NONE && addr >= 32'(MEM_BYTES)) begin
			if (fault_model < 255) begin
				fault_model++;
			end
		end else begin
			case (op)
				OP_LB:  res = {{24{bsel[7]}}, bsel};
				OP_LBU: res = {24'd0, bsel};
				OP_LH:  res = {{16{hsel[15]}}, hsel};
				OP_LHU: res = {16'd0, hsel};
				OP_LW:  res = word;
				OP_SB:  mem_model[addr[9:0]] = wdata[7:0];
				OP_SH: begin
					mem_model[hidx]         = wdata[7:0];
					mem_model[hidx + 10'd1] = wdata[15:8];
				end
				OP_SW: begin
					for (int b = 0; b < 4; b++) begin
						mem_model[widx + 10'(b)] = wdata[8*b +: 8];
					end
				end
				default: res = addr;
			endcase
			if (!(op inside {OP_SB, OP_SH, OP_SW}) && rd != 5'd0) begin
				reg_model[rd] = res;
			end
		end
	endtask

	task automatic read_check(input logic [4:0] rd);
		@(negedge clk);
		rf_raddr_i = rd;
		#1;
		check_eq($sformatf("rf_rdata_o[x%0d]", rd), rf_rdata_o, reg_model[rd]);
	endtask

	// one request from strobe to writeback, then readback of rd
	task automatic send_req(input lsu_op_e op, input logic [31:0] addr,
			input logic [31:0] wdata, input logic [4:0] rd);
		int lat;
		@(negedge clk);
		while (!ready_o) begin
			@(negedge clk);
		end
		req_i.op    = op;
		req_i.addr  = addr;
		req_i.wdata = wdata;
		req_i.rd    = rd;
		req_valid_i = 1'b1;
		@(negedge clk);
		req_valid_i = 1'b0;
		lat = 1;
		while (!done_o) begin
			@(negedge clk);
			lat++;
		end
		if (op == OP_NONE) begin
			check_eq("done_o latency", 32'(lat), 32'd2);
		end
		apply_model(op, addr, wdata, rd);
		read_check(rd);
		check_eq("fault_count_o", 32'(fault_count_o), 32'(fault_model));
		check_eq("ready_o", 32'(ready_o), 32'd1);
	endtask

	initial begin
		logic [31:0] a;
		logic [31:0] bad;
		void'($urandom(32'h226a));
		rstn        = 1'b0;
		req_valid_i = 1'b0;
		req_i       = '0;
		rf_raddr_i  = 5'd0;
		fault_model = 0;
		for (int i = 0; i < 32; i++) begin
			reg_model[i] = 32'd0;
		end
		for (int i = 0; i < MEM_BYTES; i++) begin
			mem_model[i] = 8'd0;
		end
		repeat (3) @(posedge clk);
		@(negedge clk);
		rstn = 1'b1;

		// state right after reset
		@(negedge clk);
		check_eq("ready_o", 32'(ready_o), 32'd1);
		check_eq("done_o", 32'(done_o), 32'd0);
		check_eq("fault_count_o", 32'(fault_count_o), 32'd0);
		for (int i = 0; i < 32; i++) begin
			read_check(5'(i));
		end

		// pass-through of the ALU result, the first two target x0
		for (int i = 0; i < N_NONE; i++) begin
			send_req(OP_NONE, $urandom, $urandom, (i < 2) ? 5'd0 : 5'($urandom_range(31, 1)));
		end

		// overlapping stores in the low 64 bytes, then word readback
		for (int i = 0; i < N_STORE; i++) begin
			send_req(pick_store_op($urandom), 32'($urandom_range(63, 0)), $urandom,
				5'($urandom_range(31, 1)));
		end
		for (int i = 0; i < N_LWCHK; i++) begin
			a = 32'(i * 4) | 32'($urandom_range(3, 0));
			send_req(OP_LW, a, 32'd0, 5'($urandom_range(31, 1)));
		end

		// sub-word loads at every offset of fresh words
		for (int w = 0; w < N_WORDS; w++) begin
			a = 32'(256 + w * 4);
			send_req(OP_SW, a, $urandom, 5'd0);
			for (int off = 0; off < 4; off++) begin
				send_req(OP_LB, a + 32'(off), 32'd0, 5'($urandom_range(31, 1)));
				send_req(OP_LBU, a + 32'(off), 32'd0, 5'($urandom_range(31, 1)));
				send_req(OP_LH, a + 32'(off), 32'd0, 5'($urandom_range(31, 1)));
				send_req(OP_LHU, a + 32'(off), 32'd0, 5'($urandom_range(31, 1)));
			end
		end

		// out-of-range accesses alias onto the written region
		for (int i = 0; i < N_FAULT / 3; i++) begin
			bad = (32'($urandom_range(1000, 1)) << 10) | 32'($urandom_range(63, 0));
			send_req(pick_store_op($urandom), bad, $urandom, 5'($urandom_range(31, 1)));
			send_req(OP_LW, bad & 32'h3fc, 32'd0, 5'($urandom_range(31, 1)));
			send_req(pick_load_op($urandom), bad, 32'd0, 5'($urandom_range(31, 1)));
		end

		@(negedge clk);
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule
